// ==== hw/cp0_access.sv ====
`timescale 1ns/1ps

module cp0_access (
    input  logic [4:0]     mtc0_rd,
    input  logic [2:0]     sel,
    input  logic           valid,
    input  logic           inst_mtc0,
    input  logic           inst_eret,
    input  logic           ex,
    input  cp0_pkg::word_t alu_result,
    output cp0_pkg::word_t cp0_data,
    output logic           eret_flush,
    cp0_reg_if.access      regs
);

    cp0_pkg::cp0_addr_t addr;
    logic               mtc0_we;

    assign addr = {mtc0_rd, sel};

    // A faulting instruction in this stage must not commit
    assign mtc0_we    = valid && inst_mtc0 && !ex;
    assign eret_flush = valid && inst_eret && !ex;

    assign regs.wdata = alu_result;   // mtc0 data comes through the ALU

    // Each strobe compares against its own map entry
    always_comb begin
        regs.status_we  = mtc0_we && (addr == cp0_pkg::STATUS_ADDR);
        regs.cause_we   = mtc0_we && (addr == cp0_pkg::CAUSE_ADDR);
        regs.epc_we     = mtc0_we && (addr == cp0_pkg::EPC_ADDR);
        regs.count_we   = mtc0_we && (addr == cp0_pkg::COUNT_ADDR);
        regs.compare_we = mtc0_we && (addr == cp0_pkg::COMPARE_ADDR);   // BadVAddr is read only
    end

    // mfc0 read path
    always_comb begin
        case (addr)
            cp0_pkg::BADVADDR_ADDR: cp0_data = regs.badvaddr_val;
            cp0_pkg::COUNT_ADDR:    cp0_data = regs.count_val;
            cp0_pkg::COMPARE_ADDR:  cp0_data = regs.compare_val;
            cp0_pkg::STATUS_ADDR:   cp0_data = regs.status_val;
            cp0_pkg::CAUSE_ADDR:    cp0_data = regs.cause_val;
            cp0_pkg::EPC_ADDR:      cp0_data = regs.epc_val;
            default:                cp0_data = '0;       // Unmapped reads as zero
        endcase
    end

    // Register map entries must stay distinct
    always_comb begin
        assert final ($onehot0({regs.status_we, regs.cause_we, regs.epc_we,
                                regs.count_we, regs.compare_we}))
        else $error("cp0_access: more than one write strobe active");
    end

endmodule

// ==== hw/cp0_exception_regs.sv ====
`timescale 1ns/1ps

module cp0_exception_regs (
    input  logic                clk,
    input  logic                reset,
    input  logic                ex,
    input  logic                bd,
    input  exc_pkg::exc_code_t  exc_code,
    input  cp0_pkg::word_t      pc,
    input  cp0_pkg::word_t      alu_result,
    input  cp0_pkg::ext_int_t   ext_int,
    input  logic                ti,
    input  logic                eret_flush,
    output cp0_pkg::word_t      epc,
    output logic                status_ie,
    output logic                status_exl,
    output cp0_pkg::irq_t       status_im,
    output cp0_pkg::irq_t       cause_ip,
    output logic                cause_ti,
    cp0_reg_if.exc              regs
);

    logic               cu0;
    logic               bev;
    logic               um;
    logic               erl;
    logic               exl;
    logic               ie;
    cp0_pkg::irq_t      im;
    logic               cause_bd;
    logic [7:2]         ip_hw;
    logic [1:0]         ip_sw;
    exc_pkg::exc_code_t exc_code_q;
    cp0_pkg::word_t     epc_q;
    cp0_pkg::word_t     badvaddr;

    // Status read/write fields
    always_ff @(posedge clk) begin
        if (reset) begin
            cu0 <= 1'b0;
            bev <= 1'b1;                                 // Boot vectors after reset
            um  <= 1'b0;
            erl <= 1'b0;
            ie  <= 1'b0;
        end else if (regs.status_we) begin
            cu0 <= regs.wdata[cp0_pkg::STATUS_CU0_BIT];
            bev <= regs.wdata[cp0_pkg::STATUS_BEV_BIT];
            um  <= regs.wdata[cp0_pkg::STATUS_UM_BIT];
            erl <= regs.wdata[cp0_pkg::STATUS_ERL_BIT];
            ie  <= regs.wdata[cp0_pkg::STATUS_IE_BIT];
        end
    end

    always_ff @(posedge clk) begin
        if (regs.status_we) begin
            im <= regs.wdata[cp0_pkg::STATUS_IM_LSB +: 8];  // Interrupt mask byte
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exl <= 1'b0;
        end else if (ex) begin
            exl <= 1'b1;
        end else if (eret_flush) begin
            exl <= 1'b0;
        end else if (regs.status_we) begin
            exl <= regs.wdata[cp0_pkg::STATUS_EXL_BIT];
        end
    end

    // BD and EPC only follow the first exception of a nest
    always_ff @(posedge clk) begin
        if (reset) begin
            cause_bd <= 1'b0;
        end else if (ex && !exl) begin
            cause_bd <= bd;
        end
    end

    always_ff @(posedge clk) begin
        if (ex && !exl) begin
            epc_q <= bd ? pc - cp0_pkg::INSN_BYTES : pc;   // Restart at the branch
        end else if (regs.epc_we) begin
            epc_q <= regs.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exc_code_q <= exc_pkg::INT;
        end else if (ex) begin
            exc_code_q <= exc_code;
        end
    end

    always_ff @(posedge clk) begin
        if (ex && exc_code == exc_pkg::ADES) begin
            badvaddr <= alu_result;
        end else if (ex && exc_code == exc_pkg::ADEL) begin
            badvaddr <= (pc[1:0] != 2'b00) ? pc : alu_result;  // Fetch fault or load fault
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_hw <= '0;
        end else begin
            ip_hw[7]   <= ext_int[5] | ti;               // Timer shares IP7
            ip_hw[6:2] <= ext_int[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ip_sw <= '0;
        end else if (regs.cause_we) begin
            ip_sw <= regs.wdata[cp0_pkg::CAUSE_IP_LSB +: 2];
        end
    end

    always_comb begin
        regs.status_val = '0;
        regs.status_val[cp0_pkg::STATUS_CU0_BIT]     = cu0;
        regs.status_val[cp0_pkg::STATUS_BEV_BIT]     = bev;
        regs.status_val[cp0_pkg::STATUS_IM_LSB +: 8] = im;
        regs.status_val[cp0_pkg::STATUS_UM_BIT]      = um;
        regs.status_val[cp0_pkg::STATUS_ERL_BIT]     = erl;
        regs.status_val[cp0_pkg::STATUS_EXL_BIT]     = exl;
        regs.status_val[cp0_pkg::STATUS_IE_BIT]      = ie;
    end

    always_comb begin
        regs.cause_val = '0;
        regs.cause_val[cp0_pkg::CAUSE_BD_BIT]      = cause_bd;
        regs.cause_val[cp0_pkg::CAUSE_TI_BIT]      = ti;
        regs.cause_val[cp0_pkg::CAUSE_IP_LSB +: 8] = cause_ip;
        regs.cause_val[cp0_pkg::CAUSE_EXC_LSB +: 5] = exc_code_q;
    end

    assign regs.epc_val      = epc_q;
    assign regs.badvaddr_val = badvaddr;

    assign epc        = epc_q;
    assign status_ie  = ie;
    assign status_exl = exl;
    assign status_im  = im;
    assign cause_ip   = {ip_hw, ip_sw};
    assign cause_ti   = ti;

    assert property (@(posedge clk) disable iff (reset) ex |-> !$isunknown(exc_code))
    else $error("cp0_exception_regs: exception raised with unknown code");

    // The access logic drops eret when the same instruction faults
    assert property (@(posedge clk) disable iff (reset) !(eret_flush && ex))
    else $error("cp0_exception_regs: eret flush during an exception");

endmodule

// ==== hw/cp0_pkg.sv ====
package cp0_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  cp0_addr_t;   // rd in [7:3] and sel in [2:0]
    typedef logic [7:0]  irq_t;        // IM and IP fields
    typedef logic [5:0]  ext_int_t;    // Hardware interrupt pins

    // Register map, all at sel 0
    localparam cp0_addr_t BADVADDR_ADDR = {5'd8, 3'd0};
    localparam cp0_addr_t COUNT_ADDR    = {5'd9, 3'd0};
    localparam cp0_addr_t COMPARE_ADDR  = {5'd11, 3'd0};
    localparam cp0_addr_t STATUS_ADDR   = {5'd12, 3'd0};
    localparam cp0_addr_t CAUSE_ADDR    = {5'd13, 3'd0};
    localparam cp0_addr_t EPC_ADDR      = {5'd14, 3'd0};

    localparam word_t INSN_BYTES = 32'd4;   // Branch sits one word before the slot

    // Status field positions
    localparam int STATUS_CU0_BIT = 28;
    localparam int STATUS_BEV_BIT = 22;
    localparam int STATUS_IM_LSB  = 8;
    localparam int STATUS_UM_BIT  = 4;
    localparam int STATUS_ERL_BIT = 2;
    localparam int STATUS_EXL_BIT = 1;
    localparam int STATUS_IE_BIT  = 0;

    // Cause field positions
    localparam int CAUSE_BD_BIT  = 31;
    localparam int CAUSE_TI_BIT  = 30;
    localparam int CAUSE_IP_LSB  = 8;
    localparam int CAUSE_EXC_LSB = 2;

endpackage

// ==== hw/cp0_reg_if.sv ====
`timescale 1ns/1ps

interface cp0_reg_if;

    cp0_pkg::word_t wdata;         // mtc0 source operand

    logic status_we;
    logic cause_we;
    logic epc_we;
    logic count_we;
    logic compare_we;

    cp0_pkg::word_t status_val;
    cp0_pkg::word_t cause_val;
    cp0_pkg::word_t epc_val;
    cp0_pkg::word_t badvaddr_val;
    cp0_pkg::word_t count_val;
    cp0_pkg::word_t compare_val;

    modport access (
        output wdata, status_we, cause_we, epc_we, count_we, compare_we,
        input  status_val, cause_val, epc_val, badvaddr_val, count_val, compare_val
    );

    modport exc (
        input  wdata, status_we, cause_we, epc_we,
        output status_val, cause_val, epc_val, badvaddr_val
    );

    modport timer (
        input  wdata, count_we, compare_we,
        output count_val, compare_val
    );

endinterface

// ==== hw/cp0_timer.sv ====
`timescale 1ns/1ps

module cp0_timer #(
    parameter cp0_pkg::word_t COMPARE_RESET = 32'h0001_55cc
) (
    input  logic     clk,
    input  logic     reset,
    output logic     ti,
    cp0_reg_if.timer regs
);

    logic           tick;
    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;

    always_ff @(posedge clk) begin
        if (reset) begin
            tick <= 1'b0;
        end else begin
            tick <= ~tick;                      // Half-rate enable for Count
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (regs.count_we) begin
            count <= regs.wdata;
        end else if (tick) begin
            count <= count + 32'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            compare <= COMPARE_RESET;
        end else if (regs.compare_we) begin
            compare <= regs.wdata;
        end
    end

    // Writing Compare is how software acknowledges the timer
    always_ff @(posedge clk) begin
        if (reset) begin
            ti <= 1'b0;
        end else if (regs.compare_we) begin
            ti <= 1'b0;
        end else if (count == compare) begin
            ti <= 1'b1;                         // Sticky until acknowledged
        end
    end

    assign regs.count_val   = count;
    assign regs.compare_val = compare;

    assert property (@(posedge clk) disable iff (reset) !(regs.count_we && regs.compare_we))
    else $error("cp0_timer: Count and Compare written in the same cycle");

endmodule

// ==== hw/cp0_top.sv ====
`timescale 1ns/1ps

module cp0_top #(
    parameter cp0_pkg::word_t COMPARE_RESET = 32'h0001_55cc
) (
    input  logic               clk,
    input  logic               reset,
    input  logic [4:0]         mtc0_rd,
    input  logic [2:0]         sel,
    input  logic               valid,
    input  logic               inst_mtc0,
    input  logic               inst_eret,
    input  logic               bd,
    input  logic               ex,
    input  exc_pkg::exc_code_t exc_code,
    input  cp0_pkg::word_t     alu_result,
    input  cp0_pkg::word_t     pc,
    input  cp0_pkg::ext_int_t  ext_int,
    output cp0_pkg::word_t     cp0_data,
    output logic               eret_flush,
    output cp0_pkg::word_t     epc,
    output logic               status_ie,
    output logic               status_exl,
    output cp0_pkg::irq_t      status_im,
    output cp0_pkg::irq_t      cause_ip,
    output logic               cause_ti
);

    logic ti;   // Timer interrupt flag into Cause

    cp0_reg_if regs ();

    cp0_access u_access (
        .mtc0_rd    (mtc0_rd),
        .sel        (sel),
        .valid      (valid),
        .inst_mtc0  (inst_mtc0),
        .inst_eret  (inst_eret),
        .ex         (ex),
        .alu_result (alu_result),
        .cp0_data   (cp0_data),
        .eret_flush (eret_flush),
        .regs       (regs.access)
    );

    cp0_timer #(
        .COMPARE_RESET (COMPARE_RESET)
    ) u_timer (
        .clk   (clk),
        .reset (reset),
        .ti    (ti),
        .regs  (regs.timer)
    );

    cp0_exception_regs u_exception_regs (
        .clk        (clk),
        .reset      (reset),
        .ex         (ex),
        .bd         (bd),
        .exc_code   (exc_code),
        .pc         (pc),
        .alu_result (alu_result),
        .ext_int    (ext_int),
        .ti         (ti),
        .eret_flush (eret_flush),
        .epc        (epc),
        .status_ie  (status_ie),
        .status_exl (status_exl),
        .status_im  (status_im),
        .cause_ip   (cause_ip),
        .cause_ti   (cause_ti),
        .regs       (regs.exc)
    );

endmodule

// ==== hw/exc_pkg.sv ====
package exc_pkg;

    // Architectural ExcCode values, as they land in Cause[6:2]
    typedef enum logic [4:0] {
        INT  = 5'd0,    // Interrupt
        ADEL = 5'd4,    // Address error on load or fetch
        ADES = 5'd5,    // Address error on store
        SYS  = 5'd8,    // Syscall
        BP   = 5'd9,    // Breakpoint
        RI   = 5'd10,   // Reserved instruction
        OV   = 5'd12    // Arithmetic overflow
    } exc_code_t;

endpackage

// ==== test/cp0_input.txt ====
# kind rd sel a b expected, hex columns. W write (b is ex), R read, X exception (rd code)
# X uses sel as bd, a as pc, b as alu; E eret, I ext_int=a, N wait a, C check output index a
W 0c 0 0000ff01 0 0
C 0 0 2 0 1
C 0 0 4 0 ff
W 0c 0 ffffffff 0 0
R 0c 0 0 0 1040ff17
W 0c 0 0000a501 1 0
R 0c 0 0 0 1040ff17
C 0 0 4 0 ff
W 0c 0 0000a501 0 0
R 0c 0 0 0 0000a501
R 01 0 0 0 00000000
X 0c 0 00400100 0 0
C 0 0 3 0 1
C 0 0 1 0 00400100
R 0d 0 0 0 00000030
X 08 1 00400200 0 0
R 0e 0 0 0 00400100
R 0d 0 0 0 00000020
E 0 0 0 0 0
C 0 0 3 0 0
X 0a 1 00400300 0 0
R 0e 0 0 0 004002fc
R 0d 0 0 0 80000028
E 0 0 0 0 0
X 05 0 00400400 10000003 0
R 08 0 0 0 10000003
X 04 0 00400402 20000000 0
R 08 0 0 0 00400402
X 04 0 00400408 20000001 0
R 08 0 0 0 20000001
E 0 0 0 0 0
W 09 0 00000100 0 0
W 0b 0 00000104 0 0
N 0 0 c 0 0
C 0 0 6 0 1
C 0 0 5 0 80
R 0d 0 0 0 40008010
W 0b 0 00001000 0 0
C 0 0 6 0 0
C 0 0 5 0 00
I 0 0 3f 0 0
C 0 0 5 0 fc
I 0 0 15 0 0
C 0 0 5 0 54
I 0 0 00 0 0
W 0d 0 00000300 0 0
C 0 0 5 0 03
R 0d 0 0 0 00000310

// ==== test/cp0_tb.sv ====
`timescale 1ns/1ps

module cp0_tb;

    logic               clk;
    logic               reset;
    logic [4:0]         mtc0_rd;
    logic [2:0]         sel;
    logic               valid;
    logic               inst_mtc0;
    logic               inst_eret;
    logic               bd;
    logic               ex;
    exc_pkg::exc_code_t exc_code;
    cp0_pkg::word_t     alu_result;
    cp0_pkg::word_t     pc;
    cp0_pkg::ext_int_t  ext_int;
    cp0_pkg::word_t     cp0_data;
    logic               eret_flush;
    cp0_pkg::word_t     epc;
    logic               status_ie;
    logic               status_exl;
    cp0_pkg::irq_t      status_im;
    cp0_pkg::irq_t      cause_ip;
    logic               cause_ti;

    int               fd;
    int               fields;
    int               line_count;
    int unsigned      cycle_count = 0;
    int unsigned      cycle_limit = 100;   // Raised once the input file is counted
    logic [8*128-1:0] line_buf;
    logic [63:0]      kind;
    logic [31:0]      rd_f;
    logic [31:0]      sel_f;
    logic [31:0]      a_f;
    logic [31:0]      b_f;
    logic [31:0]      exp_f;

    cp0_top u_dut (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    task automatic fail_run();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
            fail_run();
        end
    endtask

    // Output index comes from column a of a check line
    task automatic check_output(input logic [31:0] which, input logic [31:0] expected);
        case (which)
            32'd1: check_value("epc", epc, expected);
            32'd2: check_value("status_ie", {31'd0, status_ie}, expected);
            32'd3: check_value("status_exl", {31'd0, status_exl}, expected);
            32'd4: check_value("status_im", {24'd0, status_im}, expected);
            32'd5: check_value("cause_ip", {24'd0, cause_ip}, expected);
            32'd6: check_value("cause_ti", {31'd0, cause_ti}, expected);
            default: begin
                $display("Input file names an unknown output index %0d", which);
                fail_run();
            end
        endcase
    endtask

    // One operation per clock, control strobes last a single cycle
    task automatic run_operation();
        @(posedge clk);
        valid     <= 1'b0;
        inst_mtc0 <= 1'b0;
        inst_eret <= 1'b0;
        ex        <= 1'b0;
        case (kind)
            "W": begin
                mtc0_rd    <= rd_f[4:0];
                sel        <= sel_f[2:0];
                alu_result <= a_f;
                valid      <= 1'b1;
                inst_mtc0  <= 1'b1;
                ex         <= b_f[0];              // Faulting mtc0
            end
            "R": begin
                mtc0_rd <= rd_f[4:0];
                sel     <= sel_f[2:0];
                @(negedge clk);
                check_value("cp0_data", cp0_data, exp_f);
            end
            "X": begin
                exc_code   <= exc_pkg::exc_code_t'(rd_f[4:0]);
                bd         <= sel_f[0];
                pc         <= a_f;
                alu_result <= b_f;
                ex         <= 1'b1;
            end
            "E": begin
                valid     <= 1'b1;
                inst_eret <= 1'b1;
                @(negedge clk);
                check_value("eret_flush", {31'd0, eret_flush}, 32'd1);  // Same-cycle pulse
            end
            "I": ext_int <= a_f[5:0];
            "N": repeat (a_f) @(posedge clk);
            "C": begin
                @(negedge clk);
                check_output(a_f, exp_f);
            end
            default: begin
                $display("Input file holds an unknown operation kind %0s", kind);
                fail_run();
            end
        endcase
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            fail_run();
        end
    end

    initial begin
        reset      <= 1'b1;
        mtc0_rd    <= '0;
        sel        <= '0;
        valid      <= 1'b0;
        inst_mtc0  <= 1'b0;
        inst_eret  <= 1'b0;
        bd         <= 1'b0;
        ex         <= 1'b0;
        exc_code   <= exc_pkg::INT;
        alu_result <= '0;
        pc         <= '0;
        ext_int    <= '0;
        fd = $fopen("test/cp0_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the input file test/cp0_input.txt");
            fail_run();
        end
        line_count = 0;
        line_buf = '0;
        while ($fgets(line_buf, fd) != 0) begin
            line_count++;
        end
        $fclose(fd);
        cycle_limit = line_count * 16 + 100;
        fd = $fopen("test/cp0_input.txt", "r");
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        line_buf = '0;
        while ($fgets(line_buf, fd) != 0) begin
            kind = '0;
            fields = $sscanf(line_buf, "%s %h %h %h %h %h", kind, rd_f, sel_f, a_f, b_f, exp_f);
            if (kind == "#" || fields <= 0) begin
                // Comment or blank line
            end else if (fields == 6) begin
                run_operation();
            end else begin
                $display("Input file has a line that cannot be parsed: %0s", line_buf);
                fail_run();
            end
            line_buf = '0;
        end
        $fclose(fd);
        @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
hw/cp0_pkg.sv
hw/exc_pkg.sv
hw/cp0_reg_if.sv
hw/cp0_access.sv
hw/cp0_timer.sv
hw/cp0_exception_regs.sv
hw/cp0_top.sv
test/cp0_tb.sv
